// File: source/uart_pkg.sv
package uart_pkg;

  // transmitter FSM
  typedef enum logic [2:0] {
    TX_IDLE        = 3'd0,
    TX_START       = 3'd1,
    TX_DATA        = 3'd2,
    TX_STOP        = 3'd3,
    TX_WAIT_GO_LOW = 3'd4  // frame done, go still high
  } tx_state_e;

  // receiver FSM
  typedef enum logic [1:0] {
    RX_IDLE  = 2'd0,
    RX_START = 2'd1,  // waiting for mid start bit
    RX_DATA  = 2'd2,
    RX_STOP  = 2'd3
  } rx_state_e;

  // apb register offsets
  typedef enum logic [3:0] {
    REG_DATA   = 4'h0,
    REG_STATUS = 4'h4
  } reg_addr_e;

  // bit positions in the status register
  localparam int STAT_TX_BUSY    = 0;
  localparam int STAT_RX_VALID   = 1;
  localparam int STAT_RX_OVERRUN = 2;

endpackage

// File: source/uart_ctrl_if.sv
interface uart_ctrl_if;

  logic [7:0] tx_data;  // byte to send, stable while tx_go
  logic       tx_go;
  logic       tx_bsy;   // high from start bit through stop bit
  logic [7:0] rx_data;
  logic       rx_valid;
  logic       rx_ack;   // one-cycle pulse from the register block

  modport regs (
    output tx_data, tx_go, rx_ack,
    input  tx_bsy, rx_data, rx_valid
  );

  modport tx (
    input  tx_data, tx_go,
    output tx_bsy
  );

  modport rx (
    output rx_data, rx_valid,
    input  rx_ack
  );

endinterface

// File: source/uart_apb_regs.sv
module uart_apb_regs (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pslverr,
  input  logic        overrun,
  uart_ctrl_if.regs   ctrl
);

  import uart_pkg::*;

  logic        access;
  logic        addr_data;
  logic        addr_status;
  logic        unmapped;
  logic        busy;
  logic        wr_reject;
  logic        data_wr;
  logic        status_rd;
  logic        seen_bsy;   // transmitter has picked up the current go
  logic        overrun_q;  // sticky
  logic [31:0] status_word;

  assign access = psel & penable;  // no wait states

  always_comb begin
    addr_data   = 1'b0;
    addr_status = 1'b0;
    unmapped    = 1'b0;
    case (paddr)
      REG_DATA:   addr_data   = 1'b1;
      REG_STATUS: addr_status = 1'b1;
      default:    unmapped    = 1'b1;
    endcase
  end

  assign busy      = ctrl.tx_go | ctrl.tx_bsy;
  assign wr_reject = access & pwrite & addr_data & busy;
  assign data_wr   = access & pwrite & addr_data & ~busy;
  assign status_rd = access & ~pwrite & addr_status;
  assign pslverr   = (access & unmapped) | wr_reject;

  // reading DATA consumes the received byte
  assign ctrl.rx_ack = access & ~pwrite & addr_data;

  always_comb begin
    status_word                  = '0;
    status_word[STAT_TX_BUSY]    = busy;
    status_word[STAT_RX_VALID]   = ctrl.rx_valid;
    status_word[STAT_RX_OVERRUN] = overrun_q;
  end

  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      if (addr_data)        prdata = {24'h0, ctrl.rx_data};
      else if (addr_status) prdata = status_word;
    end
  end

  // holding register for the byte in flight
  always_ff @(posedge clk) begin
    if (data_wr) ctrl.tx_data <= pwdata[7:0];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ctrl.tx_go <= 1'b0;
      seen_bsy   <= 1'b0;
      overrun_q  <= 1'b0;
    end else begin
      seen_bsy <= ctrl.tx_go & (seen_bsy | ctrl.tx_bsy);

      if (data_wr) begin
        ctrl.tx_go <= 1'b1;
      end else if (ctrl.tx_go && seen_bsy && !ctrl.tx_bsy) begin
        ctrl.tx_go <= 1'b0;  // frame finished, release go
      end

      // a new overrun wins over the clearing read
      if (overrun)        overrun_q <= 1'b1;
      else if (status_rd) overrun_q <= 1'b0;
    end
  end

endmodule

// File: source/uart_tx.sv
module uart_tx #(
  parameter int CLK_FREQ  = 66_000_000,
  parameter int BAUD_RATE = 9600
) (
  input  logic       clk,
  input  logic       rst_n,
  uart_ctrl_if.tx    ctrl,
  output logic       tx
);

  import uart_pkg::*;

  localparam int BIT_TIME = CLK_FREQ / BAUD_RATE;
  localparam int CNT_W    = (BIT_TIME > 1) ? $clog2(BIT_TIME) : 1;

  tx_state_e        state;
  logic [3:0]       bit_count;  // needs to reach 8
  logic [CNT_W-1:0] bit_time_counter;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state            <= TX_IDLE;
      bit_count        <= '0;
      bit_time_counter <= '0;
      tx               <= 1'b1;
      ctrl.tx_bsy      <= 1'b0;
    end else begin
      case (state)
        TX_IDLE: begin
          if (ctrl.tx_go) begin
            ctrl.tx_bsy      <= 1'b1;
            // first tick of the start bit goes out from this edge
            bit_time_counter <= CNT_W'(BIT_TIME - 1);
            tx               <= 1'b0;
            state            <= TX_START;
          end
        end

        TX_START: begin
          if (bit_time_counter == '0) begin
            bit_time_counter <= CNT_W'(BIT_TIME - 1);
            tx               <= ctrl.tx_data[0];  // lsb first
            bit_count        <= 4'd1;
            state            <= TX_DATA;
          end else begin
            bit_time_counter <= bit_time_counter - 1'b1;
          end
        end

        TX_DATA: begin
          if (bit_time_counter == '0) begin
            bit_time_counter <= CNT_W'(BIT_TIME - 1);
            if (bit_count == 4'd8) begin
              bit_count <= '0;
              tx        <= 1'b1;  // stop bit
              state     <= TX_STOP;
            end else begin
              tx        <= ctrl.tx_data[bit_count[2:0]];
              bit_count <= bit_count + 1'b1;
            end
          end else begin
            bit_time_counter <= bit_time_counter - 1'b1;
          end
        end

        TX_STOP: begin
          if (bit_time_counter == '0) begin
            ctrl.tx_bsy <= 1'b0;
            state       <= TX_WAIT_GO_LOW;
          end else begin
            bit_time_counter <= bit_time_counter - 1'b1;
          end
        end

        TX_WAIT_GO_LOW: begin
          if (!ctrl.tx_go) state <= TX_IDLE;  // one go, one frame
        end

        default: state <= TX_IDLE;
      endcase
    end
  end

endmodule

// File: source/uart_rx.sv
module uart_rx #(
  parameter int CLK_FREQ  = 66_000_000,
  parameter int BAUD_RATE = 9600
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  uart_ctrl_if.rx    ctrl,
  output logic       overrun
);

  import uart_pkg::*;

  localparam int BIT_TIME  = CLK_FREQ / BAUD_RATE;
  localparam int CNT_W     = (BIT_TIME > 1) ? $clog2(BIT_TIME) : 1;
  localparam int HALF_LOAD = (BIT_TIME >= 2) ? BIT_TIME / 2 - 1 : 0;

  rx_state_e        state;
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             rx_fall;
  logic [2:0]       bit_count;
  logic [CNT_W-1:0] bit_time_counter;
  logic [7:0]       shift_q;

  // two-flop synchronizer, line idles high
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign rx_fall = rx_prev & ~rx_sync;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state            <= RX_IDLE;
      bit_count        <= '0;
      bit_time_counter <= '0;
      ctrl.rx_valid    <= 1'b0;
      overrun          <= 1'b0;
    end else begin
      overrun <= 1'b0;
      if (ctrl.rx_ack) ctrl.rx_valid <= 1'b0;

      case (state)
        RX_IDLE: begin
          if (rx_fall) begin
            bit_time_counter <= CNT_W'(HALF_LOAD);  // aim at mid start bit
            state            <= RX_START;
          end
        end

        RX_START: begin
          if (bit_time_counter == '0) begin
            bit_time_counter <= CNT_W'(BIT_TIME - 1);
            bit_count        <= '0;
            // glitch shorter than half a bit is ignored
            state            <= rx_sync ? RX_IDLE : RX_DATA;
          end else begin
            bit_time_counter <= bit_time_counter - 1'b1;
          end
        end

        RX_DATA: begin
          if (bit_time_counter == '0) begin
            bit_time_counter <= CNT_W'(BIT_TIME - 1);
            shift_q          <= {rx_sync, shift_q[7:1]};  // lsb arrives first
            bit_count        <= bit_count + 1'b1;
            if (bit_count == 3'd7) state <= RX_STOP;
          end else begin
            bit_time_counter <= bit_time_counter - 1'b1;
          end
        end

        RX_STOP: begin
          if (bit_time_counter == '0) begin
            if (rx_sync) begin  // framing error drops the byte
              ctrl.rx_data  <= shift_q;
              ctrl.rx_valid <= 1'b1;
              overrun       <= ctrl.rx_valid & ~ctrl.rx_ack;
            end
            state <= RX_IDLE;
          end else begin
            bit_time_counter <= bit_time_counter - 1'b1;
          end
        end

        default: state <= RX_IDLE;
      endcase
    end
  end

endmodule

// File: source/uart_top.sv
module uart_top #(
  parameter int CLK_FREQ  = 66_000_000,
  parameter int BAUD_RATE = 9600
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pslverr,
  output logic        tx,
  input  logic        rx
);

  logic overrun;  // pulse from receiver to sticky status bit

  uart_ctrl_if ctrl_if ();

  uart_apb_regs i_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pslverr (pslverr),
    .overrun (overrun),
    .ctrl    (ctrl_if.regs)
  );

  uart_tx #(
    .CLK_FREQ  (CLK_FREQ),
    .BAUD_RATE (BAUD_RATE)
  ) i_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .ctrl  (ctrl_if.tx),
    .tx    (tx)
  );

  uart_rx #(
    .CLK_FREQ  (CLK_FREQ),
    .BAUD_RATE (BAUD_RATE)
  ) i_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .ctrl    (ctrl_if.rx),
    .overrun (overrun)
  );

endmodule

// File: dv/uart_props.sv
module uart_props #(
  parameter int BIT_TIME = 8
) (
  input logic clk,
  input logic rst_n,
  input logic psel,
  input logic penable,
  input logic pslverr,
  input logic tx,
  input logic tx_bsy
);

  localparam int FRAME_LEN = 10 * BIT_TIME;

  logic tx_q;
  logic bsy_q;
  logic in_frame;
  int   frame_cnt;
  logic start_seen;
  int   pos;  // cycles since the start bit began
  logic fail_idle  = 1'b0;
  logic fail_start = 1'b0;
  logic fail_stop  = 1'b0;
  logic fail_end   = 1'b0;
  logic fail_err   = 1'b0;
  logic any_fail;  // read by the testbench at the end of the run

  assign start_seen = tx_q & ~tx & ~bsy_q;  // line fell while the transmitter was idle
  assign pos        = start_seen ? 0 : frame_cnt;
  assign any_fail   = fail_idle | fail_start | fail_stop | fail_end | fail_err;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_q      <= 1'b1;
      bsy_q     <= 1'b0;
      in_frame  <= 1'b0;
      frame_cnt <= 0;
    end else begin
      tx_q  <= tx;
      bsy_q <= tx_bsy;
      if (start_seen) begin
        in_frame  <= 1'b1;
        frame_cnt <= 1;
      end else if (in_frame) begin
        if (frame_cnt == FRAME_LEN) in_frame <= 1'b0;
        frame_cnt <= frame_cnt + 1;
      end
    end
  end

  idle_high: assert property (@(posedge clk) disable iff (!rst_n) !tx_bsy |-> tx)
    else begin
      $error("tx low while the transmitter is idle");
      fail_idle = 1'b1;
    end

  start_low: assert property (@(posedge clk) disable iff (!rst_n)
    (start_seen || in_frame) && pos < BIT_TIME |-> !tx)
    else begin
      $error("start bit shorter than one bit time");
      fail_start = 1'b1;
    end

  // stop bit spans 9 to 10 bit times after the start
  stop_high: assert property (@(posedge clk) disable iff (!rst_n)
    in_frame && pos >= 9 * BIT_TIME && pos < FRAME_LEN |-> tx)
    else begin
      $error("stop bit not high for one bit time");
      fail_stop = 1'b1;
    end

  bsy_end: assert property (@(posedge clk) disable iff (!rst_n)
    in_frame && pos == FRAME_LEN |-> !tx_bsy)
    else begin
      $error("tx_bsy still high after the stop bit");
      fail_end = 1'b1;
    end

  err_in_access: assert property (@(posedge clk) disable iff (!rst_n)
    pslverr |-> psel && penable)
    else begin
      $error("pslverr outside an access cycle");
      fail_err = 1'b1;
    end

endmodule

bind uart_top uart_props #(
  .BIT_TIME (CLK_FREQ / BAUD_RATE)
) i_props (
  .clk     (clk),
  .rst_n   (rst_n),
  .psel    (psel),
  .penable (penable),
  .pslverr (pslverr),
  .tx      (tx),
  .tx_bsy  (ctrl_if.tx_bsy)
);

// File: dv/uart_tb.sv
module uart_tb;

  import uart_pkg::*;

  parameter int unsigned SEED = 32'h3fecd4e9;

  localparam int CLK_PERIOD   = 8;
  localparam int BIT_TIME     = 8;  // CLK_FREQ 8 over BAUD_RATE 1
  localparam int FRAME_CYCLES = 10 * BIT_TIME;
  localparam int N_FRAMES     = 6;
  localparam int WATCHDOG     = N_FRAMES * FRAME_CYCLES * CLK_PERIOD + 3000;
  localparam int MAX_POLLS    = 2 * FRAME_CYCLES;

  localparam logic [31:0] BUSY_BIT    = 32'h1 << STAT_TX_BUSY;
  localparam logic [31:0] VALID_BIT   = 32'h1 << STAT_RX_VALID;
  localparam logic [31:0] OVERRUN_BIT = 32'h1 << STAT_RX_OVERRUN;

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pslverr;
  logic        serial;  // tx looped back to rx

  int   errors;
  int   test_errors;
  int   tests_run;
  int   tests_failed;
  logic props_failed;

  uart_top #(
    .CLK_FREQ  (8),
    .BAUD_RATE (1)
  ) i_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pslverr (pslverr),
    .tx      (serial),
    .rx      (serial)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG);
    $display("watchdog expired before the tests finished");
    $display("TESTS FAILED");
    $finish;
  end

  // setup cycle then access cycle with the response sampled mid access
  task automatic apb_xfer(input logic write, input logic [3:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #(CLK_PERIOD / 4);
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic poll_status(input logic [31:0] mask, input logic want);
    logic [31:0] st;
    logic        err;
    int          polls;
    polls = 0;
    do begin
      apb_xfer(1'b0, REG_STATUS, 32'h0, st, err);
      polls++;
    end while ((|(st & mask)) !== want && polls < MAX_POLLS);
    if ((|(st & mask)) !== want) begin
      $display("status bits 0x%08h never reached %0b", mask, want);
      test_errors++;
    end
  endtask

  // waits for the start bit and then the whole frame through the receiver
  task automatic wait_frame_end();
    int cycles;
    cycles = 0;
    while (serial !== 1'b0 && cycles < FRAME_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (serial !== 1'b0) begin
      $display("no start bit appeared on the serial line");
      test_errors++;
    end else begin
      repeat (FRAME_CYCLES + 4) @(negedge clk);
    end
  endtask

  task automatic end_test(input string name);
    if (i_dut.i_props.any_fail && !props_failed) begin
      $display("a protocol assertion in uart_props failed");
      props_failed = 1'b1;
      test_errors++;
    end
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, test_errors);
      tests_failed++;
      errors += test_errors;
    end
    test_errors = 0;
  endtask

  initial begin
    logic [31:0] rd;
    logic        err;
    logic [7:0]  b0;
    logic [7:0]  b1;
    void'($urandom(SEED));
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    props_failed = 1'b0;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = 4'h0;
    pwdata  = 32'h0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    @(negedge clk);
    check_value("tx", {31'h0, serial}, 32'h1);
    apb_xfer(1'b0, REG_STATUS, 32'h0, rd, err);
    check_value("status", rd, 32'h0);
    end_test("reset_values");

    repeat (2) begin
      b0 = 8'($urandom());
      poll_status(BUSY_BIT, 1'b0);
      apb_xfer(1'b1, REG_DATA, {24'h0, b0}, rd, err);
      check_value("pslverr", {31'h0, err}, 32'h0);
      poll_status(VALID_BIT, 1'b1);
      apb_xfer(1'b0, REG_DATA, 32'h0, rd, err);
      check_value("prdata", rd, {24'h0, b0});
      apb_xfer(1'b0, REG_STATUS, 32'h0, rd, err);
      check_value("rx_valid", rd & VALID_BIT, 32'h0);
    end
    end_test("loopback");

    // all-zero byte still needs a clean stop bit
    poll_status(BUSY_BIT, 1'b0);
    apb_xfer(1'b1, REG_DATA, 32'h0, rd, err);
    wait_frame_end();
    apb_xfer(1'b0, REG_DATA, 32'h0, rd, err);
    check_value("prdata", rd, 32'h0);
    apb_xfer(1'b0, REG_STATUS, 32'h0, rd, err);
    check_value("status", rd, 32'h0);
    end_test("frame_shape");

    b0 = 8'($urandom());
    do begin
      b1 = 8'($urandom());
    end while (b1 == b0);  // the two bytes must be told apart
    apb_xfer(1'b1, REG_DATA, {24'h0, b0}, rd, err);
    check_value("pslverr", {31'h0, err}, 32'h0);
    apb_xfer(1'b0, REG_STATUS, 32'h0, rd, err);
    check_value("status", rd, BUSY_BIT);
    apb_xfer(1'b1, REG_DATA, {24'h0, b1}, rd, err);
    check_value("pslverr", {31'h0, err}, 32'h1);
    poll_status(VALID_BIT, 1'b1);
    apb_xfer(1'b0, REG_DATA, 32'h0, rd, err);
    check_value("prdata", rd, {24'h0, b0});
    poll_status(BUSY_BIT, 1'b0);
    repeat (2 * BIT_TIME) @(negedge clk);
    apb_xfer(1'b0, REG_STATUS, 32'h0, rd, err);
    check_value("status", rd, 32'h0);
    end_test("busy_reject");

    apb_xfer(1'b0, 4'h8, 32'h0, rd, err);
    check_value("pslverr", {31'h0, err}, 32'h1);
    apb_xfer(1'b1, 4'h8, 32'hffff_ffff, rd, err);
    check_value("pslverr", {31'h0, err}, 32'h1);
    apb_xfer(1'b0, REG_STATUS, 32'h0, rd, err);
    check_value("status", rd, 32'h0);
    end_test("unmapped");

    b0 = 8'($urandom());
    do begin
      b1 = 8'($urandom());
    end while (b1 == b0);
    apb_xfer(1'b1, REG_DATA, {24'h0, b0}, rd, err);
    poll_status(VALID_BIT, 1'b1);
    poll_status(BUSY_BIT, 1'b0);
    apb_xfer(1'b1, REG_DATA, {24'h0, b1}, rd, err);
    check_value("pslverr", {31'h0, err}, 32'h0);
    wait_frame_end();
    apb_xfer(1'b0, REG_STATUS, 32'h0, rd, err);
    check_value("status", rd, VALID_BIT | OVERRUN_BIT);
    apb_xfer(1'b0, REG_DATA, 32'h0, rd, err);
    check_value("prdata", rd, {24'h0, b1});
    apb_xfer(1'b0, REG_STATUS, 32'h0, rd, err);
    check_value("status", rd, 32'h0);
    end_test("overrun");

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
source/uart_pkg.sv
source/uart_ctrl_if.sv
source/uart_apb_regs.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_top.sv
dv/uart_props.sv
dv/uart_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= uart_tb
SEED      ?= 32'h3fecd4e9
LOG       ?= sim.log
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) "-GSEED=$(SEED)" \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
